//--- rtl/aluCore.sv
`timescale 1ns/1ps
`include "alu_cfg.svh"

module aluCore
    import aluPkg::*;
(
    input  aluOp     op,
    input  dataWord  rs,
    input  dataWord  rt,
    input  shamtWord shamt,
    output dataWord  result,
    output dataWord  lo,
    output dataWord  hi,
    output bflagWord bflag,
    output logic     writesHiLo
);

    localparam int DataW = `ALU_DATA_W;

    logic [2*DataW-1:0] prodS;
    logic [2*DataW-1:0] prodU;

    logic signed [DataW:0] divSNum;
    logic signed [DataW:0] divSDen;
    logic signed [DataW:0] divSQuot;
    logic signed [DataW:0] divSRem;

    dataWord divUDen;
    dataWord divUQuot;
    dataWord divURem;

    logic rtZero;
    logic rsZero;
    logic rsNeg;

    assign rtZero = (rt == '0);
    assign rsZero = (rs == '0);
    assign rsNeg  = rs[DataW-1];

    // Sign-extended operands give the signed product in the low 2*DataW bits.
    assign prodS = {{DataW{rs[DataW-1]}}, rs} * {{DataW{rt[DataW-1]}}, rt};
    assign prodU = {{DataW{1'b0}}, rs} * {{DataW{1'b0}}, rt};

    // One extra bit keeps the most negative value divided by -1 well defined.
    // A zero divisor is replaced by one; its result is overridden below.
    assign divSNum  = $signed({rs[DataW-1], rs});
    assign divSDen  = rtZero ? (DataW+1)'(1) : $signed({rt[DataW-1], rt});
    assign divSQuot = divSNum / divSDen;
    assign divSRem  = divSNum % divSDen;

    assign divUDen  = rtZero ? dataWord'(1) : rt;
    assign divUQuot = rs / divUDen;
    assign divURem  = rs % divUDen;

    always_comb begin
        result     = '0;
        lo         = '0;
        hi         = '0;
        writesHiLo = 1'b0;
        bflag      = BflagNone;

        case (op)
            OpAdd:  result = rs + rt;
            OpSub:  result = rs - rt;
            OpMultS: begin
                writesHiLo = 1'b1;
                lo         = prodS[DataW-1:0];
                hi         = prodS[2*DataW-1:DataW];
            end
            OpMultU: begin
                writesHiLo = 1'b1;
                lo         = prodU[DataW-1:0];
                hi         = prodU[2*DataW-1:DataW];
            end
            OpDivS: begin
                writesHiLo = 1'b1;
                if (rtZero) begin
                    lo = '1;  // Divide by zero gives all ones and the dividend.
                    hi = rs;
                end else begin
                    lo = divSQuot[DataW-1:0];
                    hi = divSRem[DataW-1:0];
                end
            end
            OpDivU: begin
                writesHiLo = 1'b1;
                if (rtZero) begin
                    lo = '1;
                    hi = rs;
                end else begin
                    lo = divUQuot;
                    hi = divURem;
                end
            end
            OpAnd:  result = rs & rt;
            OpOr:   result = rs | rt;
            OpXor:  result = rs ^ rt;
            // The stage before has already chosen between shift and rt[4:0].
            OpSll, OpSllv: result = rs << shamt;
            OpSrl, OpSrlv: result = rs >> shamt;
            OpSra, OpSrav: result = dataWord'($signed(rs) >>> shamt);
            OpEq:   result = dataWord'(rs == rt);
            OpGez:  result = dataWord'(!rsNeg);
            OpGz:   result = dataWord'(!rsNeg && !rsZero);
            OpLez:  result = dataWord'(rsNeg || rsZero);
            OpLz:   result = dataWord'(rsNeg);
            OpNe:   result = dataWord'(rs != rt);
            default: begin
            end
        endcase

        if (op inside {[OpEq:OpNe]}) begin
            bflag = bflagWord'(op - OpEq);  // Equal is 0, not equal is 5.
        end
    end

endmodule

//--- rtl/aluPipeTop.sv
`timescale 1ns/1ps

module aluPipeTop
    import aluPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     issue,
    input  aluOp     op,
    input  dataWord  rs,
    input  dataWord  rt,
    input  shamtWord shift,
    output logic     outValid,
    output dataWord  result,
    output dataWord  lo,
    output dataWord  hi,
    output bflagWord bflag
);

    logic     s1Valid;
    aluOp     s1Op;
    dataWord  s1Rs;
    dataWord  s1Rt;
    shamtWord s1Shamt;

    logic     s2Valid;
    dataWord  s2Result;
    dataWord  s2Lo;
    dataWord  s2Hi;
    bflagWord s2Bflag;
    logic     s2WritesHiLo;

    operandStage stage1_i (
        .clk     (clk),
        .rstN    (rstN),
        .issue   (issue),
        .op      (op),
        .rs      (rs),
        .rt      (rt),
        .shift   (shift),
        .s1Valid (s1Valid),
        .s1Op    (s1Op),
        .s1Rs    (s1Rs),
        .s1Rt    (s1Rt),
        .s1Shamt (s1Shamt)
    );

    executeStage stage2_i (
        .clk          (clk),
        .rstN         (rstN),
        .s1Valid      (s1Valid),
        .s1Op         (s1Op),
        .s1Rs         (s1Rs),
        .s1Rt         (s1Rt),
        .s1Shamt      (s1Shamt),
        .s2Valid      (s2Valid),
        .s2Result     (s2Result),
        .s2Lo         (s2Lo),
        .s2Hi         (s2Hi),
        .s2Bflag      (s2Bflag),
        .s2WritesHiLo (s2WritesHiLo)
    );

    hiLoStage stage3_i (
        .clk          (clk),
        .rstN         (rstN),
        .s2Valid      (s2Valid),
        .s2Result     (s2Result),
        .s2Lo         (s2Lo),
        .s2Hi         (s2Hi),
        .s2Bflag      (s2Bflag),
        .s2WritesHiLo (s2WritesHiLo),
        .outValid     (outValid),
        .result       (result),
        .lo           (lo),
        .hi           (hi),
        .bflag        (bflag)
    );

endmodule

//--- rtl/aluPkg.sv
`include "alu_cfg.svh"

package aluPkg;

    typedef logic [`ALU_DATA_W-1:0]  dataWord;
    typedef logic [`ALU_SHAMT_W-1:0] shamtWord;
    typedef logic [`ALU_BFLAG_W-1:0] bflagWord;

    // Operation codes, numbered as in the ALU control field.
    typedef enum logic [`ALU_OP_W-1:0] {
        OpAdd   = 0,
        OpSub   = 1,
        OpMultS = 2,
        OpMultU = 3,
        OpDivS  = 4,
        OpDivU  = 5,
        OpAnd   = 6,
        OpOr    = 7,
        OpXor   = 8,
        OpSll   = 9,
        OpSllv  = 10,
        OpSrl   = 11,
        OpSrlv  = 12,
        OpSra   = 13,
        OpSrav  = 14,
        OpEq    = 15,  // First compare; bflag counts from here.
        OpGez   = 16,
        OpGz    = 17,
        OpLez   = 18,
        OpLz    = 19,
        OpNe    = 20
    } aluOp;

    // Branch kind reported by every operation that is not a compare.
    localparam bflagWord BflagNone = bflagWord'(7);

endpackage

//--- rtl/alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Operand, result, HI and LO width.
`define ALU_DATA_W 32

// Shift amount, wide enough for any shift of a data word.
`define ALU_SHAMT_W 5

// Operation code width.
`define ALU_OP_W 5

// Branch-kind code width.
`define ALU_BFLAG_W 3

`endif

//--- rtl/executeStage.sv
`timescale 1ns/1ps

module executeStage
    import aluPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     s1Valid,
    input  aluOp     s1Op,
    input  dataWord  s1Rs,
    input  dataWord  s1Rt,
    input  shamtWord s1Shamt,
    output logic     s2Valid,
    output dataWord  s2Result,
    output dataWord  s2Lo,
    output dataWord  s2Hi,
    output bflagWord s2Bflag,
    output logic     s2WritesHiLo
);

    dataWord  aluResult;
    dataWord  aluLo;
    dataWord  aluHi;
    bflagWord aluBflag;
    logic     aluWritesHiLo;

    aluCore core_i (
        .op         (s1Op),
        .rs         (s1Rs),
        .rt         (s1Rt),
        .shamt      (s1Shamt),
        .result     (aluResult),
        .lo         (aluLo),
        .hi         (aluHi),
        .bflag      (aluBflag),
        .writesHiLo (aluWritesHiLo)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s2Valid <= 1'b0;
        end else begin
            s2Valid <= s1Valid;
        end
    end

    // Registering here splits the multiply and divide paths from the HI/LO update.
    always_ff @(posedge clk) begin
        if (s1Valid) begin
            s2Result     <= aluResult;
            s2Lo         <= aluLo;
            s2Hi         <= aluHi;
            s2Bflag      <= aluBflag;
            s2WritesHiLo <= aluWritesHiLo;
        end
    end

endmodule

//--- rtl/hiLoStage.sv
`timescale 1ns/1ps

module hiLoStage
    import aluPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     s2Valid,
    input  dataWord  s2Result,
    input  dataWord  s2Lo,
    input  dataWord  s2Hi,
    input  bflagWord s2Bflag,
    input  logic     s2WritesHiLo,
    output logic     outValid,
    output dataWord  result,
    output dataWord  lo,
    output dataWord  hi,
    output bflagWord bflag
);

    logic hiLoWrite;

    // Only multiply and divide touch the architectural HI/LO pair.
    assign hiLoWrite = s2Valid && s2WritesHiLo;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= s2Valid;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hi <= '0;
            lo <= '0;
        end else if (hiLoWrite) begin
            hi <= s2Hi;
            lo <= s2Lo;
        end
    end

    // Result and branch kind hold their last value between operations.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result <= '0;
            bflag  <= '0;
        end else if (s2Valid) begin
            result <= s2Result;
            bflag  <= s2Bflag;
        end
    end

endmodule

//--- rtl/operandStage.sv
`timescale 1ns/1ps
`include "alu_cfg.svh"

module operandStage
    import aluPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     issue,
    input  aluOp     op,
    input  dataWord  rs,
    input  dataWord  rt,
    input  shamtWord shift,
    output logic     s1Valid,
    output aluOp     s1Op,
    output dataWord  s1Rs,
    output dataWord  s1Rt,
    output shamtWord s1Shamt
);

    logic     variableShift;
    shamtWord shamtSel;

    // Variable shifts take their amount from the low bits of rt.
    assign variableShift = (op == OpSllv) || (op == OpSrlv) || (op == OpSrav);
    assign shamtSel      = variableShift ? rt[`ALU_SHAMT_W-1:0] : shift;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= issue;
        end
    end

    // Operands only move when something is issued.
    always_ff @(posedge clk) begin
        if (issue) begin
            s1Op    <= op;
            s1Rs    <= rs;
            s1Rt    <= rt;
            s1Shamt <= shamtSel;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Builds the ALU pipeline testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module aluPipeTb \
    -Mdir obj_dir -o aluPipeSim -f tb.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/aluPipeSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

exit 0

//--- tb.f
+incdir+rtl
+incdir+verification
rtl/aluPkg.sv
rtl/operandStage.sv
rtl/aluCore.sv
rtl/executeStage.sv
rtl/hiLoStage.sv
rtl/aluPipeTop.sv
verification/aluPipeTb.sv

//--- verification/aluVectors.svh
`ifndef ALU_VECTORS_SVH
`define ALU_VECTORS_SVH

// One directed case. The lo and hi columns count only when hiLoSet is high.
// Other rows expect whatever the last multiply or divide left behind.
typedef struct packed {
    aluOp     op;
    dataWord  rs;
    dataWord  rt;
    shamtWord shift;
    dataWord  expResult;
    dataWord  expLo;
    dataWord  expHi;
    bflagWord expBflag;
    logic     hiLoSet;
} vecRow;

// Each row holds op, rs, rt, shift, result, lo, hi, bflag and hiLoSet in that order.
vecRow vectors [36] = '{
    '{OpAdd,   32'h5,        32'h7,        5'd0,  32'hC,        32'h0, 32'h0, 3'd7, 1'b0},
    '{OpAdd,   32'hFFFFFFFF, 32'h1,        5'd0,  32'h0,        32'h0, 32'h0, 3'd7, 1'b0},
    '{OpSub,   32'h3,        32'h5,        5'd0,  32'hFFFFFFFE, 32'h0, 32'h0, 3'd7, 1'b0},
    '{OpAnd,   32'hF0F0F0F0, 32'hFF00FF00, 5'd0,  32'hF000F000, 32'h0, 32'h0, 3'd7, 1'b0},
    '{OpOr,    32'hF0F0F0F0, 32'h0F0F0000, 5'd0,  32'hFFFFF0F0, 32'h0, 32'h0, 3'd7, 1'b0},
    '{OpXor,   32'hAAAA5555, 32'hFFFF0000, 5'd0,  32'h55555555, 32'h0, 32'h0, 3'd7, 1'b0},
    '{OpSll,   32'h1,        32'h1F,       5'd4,  32'h10,       32'h0, 32'h0, 3'd7, 1'b0},
    '{OpSllv,  32'h3,        32'hFFFFFF24, 5'd1,  32'h30,       32'h0, 32'h0, 3'd7, 1'b0},
    '{OpSrl,   32'h80000000, 32'h0,        5'd31, 32'h1,        32'h0, 32'h0, 3'd7, 1'b0},
    '{OpSrlv,  32'hF0000000, 32'h104,      5'd0,  32'h0F000000, 32'h0, 32'h0, 3'd7, 1'b0},
    '{OpSra,   32'h80000000, 32'h0,        5'd4,  32'hF8000000, 32'h0, 32'h0, 3'd7, 1'b0},
    '{OpSra,   32'h40000000, 32'h0,        5'd4,  32'h04000000, 32'h0, 32'h0, 3'd7, 1'b0},
    '{OpSrav,  32'hFFFFFF00, 32'h28,       5'd3,  32'hFFFFFFFF, 32'h0, 32'h0, 3'd7, 1'b0},
    '{OpSrav,  32'h80000000, 32'hFFFFFFFF, 5'd0,  32'hFFFFFFFF, 32'h0, 32'h0, 3'd7, 1'b0},
    // Multiply and divide, then plain operations that must leave HI/LO alone.
    '{OpMultS, 32'hFFFFFFFE, 32'h3, 5'd0, 32'h0, 32'hFFFFFFFA, 32'hFFFFFFFF, 3'd7, 1'b1},
    '{OpMultU, 32'hFFFFFFFF, 32'h2, 5'd0, 32'h0, 32'hFFFFFFFE, 32'h1,        3'd7, 1'b1},
    '{OpAdd,   32'h1,        32'h1, 5'd0, 32'h2, 32'h0,        32'h0,        3'd7, 1'b0},
    '{OpMultS, 32'h7FFFFFFF, 32'h7FFFFFFF, 5'd0, 32'h0, 32'h1, 32'h3FFFFFFF, 3'd7, 1'b1},
    '{OpDivS,  32'hFFFFFFF9, 32'h2, 5'd0, 32'h0, 32'hFFFFFFFD, 32'hFFFFFFFF, 3'd7, 1'b1},
    '{OpDivU,  32'h64,       32'h7, 5'd0, 32'h0, 32'hE,        32'h2,        3'd7, 1'b1},
    '{OpDivS,  32'h12345678, 32'h0, 5'd0, 32'h0, 32'hFFFFFFFF, 32'h12345678, 3'd7, 1'b1},
    '{OpDivU,  32'hABCD,     32'h0, 5'd0, 32'h0, 32'hFFFFFFFF, 32'hABCD,     3'd7, 1'b1},
    '{OpDivS,  32'h80000000, 32'hFFFFFFFF, 5'd0, 32'h0, 32'h80000000, 32'h0, 3'd7, 1'b1},
    '{OpXor,   32'h0,        32'h0, 5'd0, 32'h0, 32'h0,        32'h0,        3'd7, 1'b0},
    '{OpEq,    32'h1234,     32'h1234, 5'd0, 32'h1, 32'h0, 32'h0, 3'd0, 1'b0},
    '{OpEq,    32'h1234,     32'h1235, 5'd0, 32'h0, 32'h0, 32'h0, 3'd0, 1'b0},
    '{OpGez,   32'h0,        32'h0,    5'd0, 32'h1, 32'h0, 32'h0, 3'd1, 1'b0},
    '{OpGez,   32'h80000000, 32'h0,    5'd0, 32'h0, 32'h0, 32'h0, 3'd1, 1'b0},
    '{OpGz,    32'h0,        32'h0,    5'd0, 32'h0, 32'h0, 32'h0, 3'd2, 1'b0},
    '{OpGz,    32'h1,        32'h0,    5'd0, 32'h1, 32'h0, 32'h0, 3'd2, 1'b0},
    '{OpLez,   32'h0,        32'h0,    5'd0, 32'h1, 32'h0, 32'h0, 3'd3, 1'b0},
    '{OpLez,   32'h5,        32'h0,    5'd0, 32'h0, 32'h0, 32'h0, 3'd3, 1'b0},
    '{OpLz,    32'hFFFFFFFF, 32'h0,    5'd0, 32'h1, 32'h0, 32'h0, 3'd4, 1'b0},
    '{OpLz,    32'h0,        32'h0,    5'd0, 32'h0, 32'h0, 32'h0, 3'd4, 1'b0},
    '{OpNe,    32'h1,        32'h2,    5'd0, 32'h1, 32'h0, 32'h0, 3'd5, 1'b0},
    '{OpNe,    32'h7,        32'h7,    5'd0, 32'h0, 32'h0, 32'h0, 3'd5, 1'b0}
};

`endif

//--- verification/aluPipeTb.sv
`timescale 1ns/1ps
`include "alu_cfg.svh"

module aluPipeTb
    import aluPkg::*;
();

    localparam int DataW     = `ALU_DATA_W;
    localparam int Latency   = 3;
    localparam int WaitLimit = 20;
    localparam int NumRandom = 200;

    typedef struct packed {
        aluOp     op;
        dataWord  result;
        dataWord  lo;
        dataWord  hi;
        bflagWord bflag;
        int       cycle;
    } expEntry;

    logic     clk;
    logic     rstN;
    logic     issue;
    aluOp     op;
    dataWord  rs;
    dataWord  rt;
    shamtWord shift;
    logic     outValid;
    dataWord  result;
    dataWord  lo;
    dataWord  hi;
    bflagWord bflag;

    expEntry expQ[$];
    int      cycleCount = 0;
    int      issuedCount = 0;
    int      checkedCount = 0;
    dataWord archLo = '0;   // Expected HI/LO after the latest issued operation.
    dataWord archHi = '0;

    `include "aluVectors.svh"

    aluPipeTop dut_i (
        .clk      (clk),
        .rstN     (rstN),
        .issue    (issue),
        .op       (op),
        .rs       (rs),
        .rt       (rt),
        .shift    (shift),
        .outValid (outValid),
        .result   (result),
        .lo       (lo),
        .hi       (hi),
        .bflag    (bflag)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycleCount <= cycleCount + 1;

    task automatic failRun(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "Stopping at the first mismatch.");
    endtask

    task automatic stopOnTimeout();
        $display("Test failed");
        $fatal(1, "outValid never arrived within %0d cycles.", WaitLimit);
    endtask

    // Expected behavior of one operation, worked out from the ISA rules.
    task automatic modelOp(input aluOp mOp, input dataWord a, input dataWord b,
                           input shamtWord sh, output dataWord res, output bflagWord bf);
        logic signed [DataW-1:0] aS;
        logic signed [DataW-1:0] bS;
        longint                  aL;
        longint                  bL;
        longint                  full;
        logic [2*DataW-1:0]      fullU;
        shamtWord                amt;
        aS  = a;
        bS  = b;
        aL  = longint'(aS);
        bL  = longint'(bS);
        amt = (mOp inside {OpSllv, OpSrlv, OpSrav}) ? b[`ALU_SHAMT_W-1:0] : sh;
        res = '0;
        bf  = 3'd7;
        case (mOp)
            OpAdd: res = a + b;
            OpSub: res = a - b;
            OpMultS: begin
                full   = aL * bL;
                archLo = full[DataW-1:0];
                archHi = full[2*DataW-1:DataW];
            end
            OpMultU: begin
                fullU  = {{DataW{1'b0}}, a} * {{DataW{1'b0}}, b};
                archLo = fullU[DataW-1:0];
                archHi = fullU[2*DataW-1:DataW];
            end
            OpDivS, OpDivU: begin
                if (b == '0) begin
                    archLo = '1;
                    archHi = a;
                end else if (mOp == OpDivS) begin
                    archLo = dataWord'(aL / bL);  // Wide math keeps -2^31 / -1 defined.
                    archHi = dataWord'(aL % bL);
                end else begin
                    archLo = a / b;
                    archHi = a % b;
                end
            end
            OpAnd: res = a & b;
            OpOr:  res = a | b;
            OpXor: res = a ^ b;
            OpSll, OpSllv: res = a << amt;
            OpSrl, OpSrlv: res = a >> amt;
            OpSra, OpSrav: res = aS >>> amt;
            OpEq:  res = (a == b) ? 32'd1 : 32'd0;
            OpGez: res = (aS >= 0) ? 32'd1 : 32'd0;
            OpGz:  res = (aS > 0) ? 32'd1 : 32'd0;
            OpLez: res = (aS <= 0) ? 32'd1 : 32'd0;
            OpLz:  res = (aS < 0) ? 32'd1 : 32'd0;
            OpNe:  res = (a != b) ? 32'd1 : 32'd0;
            default: res = '0;
        endcase
        if (mOp >= OpEq) begin
            bf = bflagWord'(int'(mOp) - 15);
        end
    endtask

    task automatic issueOp(input aluOp iOp, input dataWord a, input dataWord b,
                           input shamtWord sh, input dataWord eRes, input bflagWord eBf);
        expEntry e;
        @(posedge clk);
        issue    <= 1'b1;
        op       <= iOp;
        rs       <= a;
        rt       <= b;
        shift    <= sh;
        e.op     = iOp;
        e.result = eRes;
        e.lo     = archLo;
        e.hi     = archHi;
        e.bflag  = eBf;
        e.cycle  = cycleCount + 1;  // The DUT samples this issue on the next edge.
        expQ.push_back(e);
        issuedCount++;
    endtask

    task automatic checkOutput(input expEntry e);
        assert (cycleCount - e.cycle == Latency)
            else failRun($sformatf("op %0d came out after %0d cycles", e.op,
                                   cycleCount - e.cycle));
        assert (result === e.result)
            else failRun($sformatf("op %0d result %h, expected %h", e.op, result, e.result));
        assert (lo === e.lo)
            else failRun($sformatf("op %0d lo %h, expected %h", e.op, lo, e.lo));
        assert (hi === e.hi)
            else failRun($sformatf("op %0d hi %h, expected %h", e.op, hi, e.hi));
        assert (bflag === e.bflag)
            else failRun($sformatf("op %0d bflag %0d, expected %0d", e.op, bflag, e.bflag));
    endtask

    // Every outValid pulse must match the oldest operation still in flight.
    initial begin : checkOutputs
        expEntry e;
        forever begin
            @(posedge clk);
            if (rstN && outValid) begin
                assert (expQ.size() > 0) else failRun("outValid pulse with nothing issued");
                e = expQ.pop_front();
                checkOutput(e);
                checkedCount++;
            end else if (expQ.size() > 0 && cycleCount - expQ[0].cycle > WaitLimit) begin
                stopOnTimeout();
            end
        end
    end

    initial begin : runTest
        vecRow       row;
        aluOp        rOp;
        dataWord     rA;
        dataWord     rB;
        dataWord     rRes;
        shamtWord    rSh;
        bflagWord    rBf;
        int          waited;
        void'($urandom(50644));
        rstN  = 1'b0;
        issue = 1'b0;
        op    = OpAdd;
        rs    = '0;
        rt    = '0;
        shift = '0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;

        repeat (3) begin
            @(posedge clk);
            assert (outValid === 1'b0 && result === '0 && lo === '0 && hi === '0 &&
                    bflag === '0)
                else failRun("outputs are not idle after reset");
        end

        foreach (vectors[i]) begin
            row = vectors[i];
            if (row.hiLoSet) begin
                archLo = row.expLo;
                archHi = row.expHi;
            end
            issueOp(row.op, row.rs, row.rt, row.shift, row.expResult, row.expBflag);
        end

        for (int i = 0; i < NumRandom; i++) begin
            rOp = aluOp'($urandom_range(0, 20));
            rA  = $urandom();
            rB  = ($urandom_range(0, 7) == 0) ? '0 : $urandom();  // Divide by zero now and then.
            rSh = shamtWord'($urandom_range(0, 31));
            modelOp(rOp, rA, rB, rSh, rRes, rBf);
            issueOp(rOp, rA, rB, rSh, rRes, rBf);
        end
        @(posedge clk);
        issue <= 1'b0;

        waited = 0;
        while (checkedCount < issuedCount) begin
            @(posedge clk);
            waited++;
            if (waited > WaitLimit) begin
                stopOnTimeout();
            end
        end

        // A few quiet cycles catch any extra pulse.
        repeat (2 * Latency) @(posedge clk);
        if (checkedCount == issuedCount && expQ.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "Only %0d of %0d operations came out.", checkedCount, issuedCount);
        end
    end

endmodule
